// ==== panel_pkg.sv ====
`default_nettype none

package panel_pkg;

    // ==================================================================
    // Store and panel widths
    // ==================================================================
    parameter int INSTR_W      = 32;   // Instruction word
    parameter int INSTR_ADDR_W = 5;    // 32 instruction slots
    parameter int UB_DATA_W    = 256;  // Unified buffer word
    parameter int UB_WR_ADDR_W = 8;
    parameter int UB_RD_ADDR_W = 9;    // MSB is bank select
    parameter int WT_DATA_W    = 64;
    parameter int WT_ADDR_W    = 10;
    parameter int SW_W         = 16;   // Slide switches
    parameter int BTN_W        = 5;

    // Bit positions in the raw button vector
    parameter int BTN_UP     = 4;
    parameter int BTN_DOWN   = 3;
    parameter int BTN_LEFT   = 2;
    parameter int BTN_RIGHT  = 1;
    parameter int BTN_CENTER = 0;

    parameter int SEG_W  = 7;   // A to G, no dp
    parameter int DIGITS = 4;
    parameter int DISP_W = 16;  // One nibble per digit

    // Panel operating modes, code shown on digit 3
    typedef enum logic [2:0] {
        IDLE    = 3'd0,
        INSTR   = 3'd1,
        DATA    = 3'd2,
        WEIGHT  = 3'd3,
        EXECUTE = 3'd4,
        RESULTS = 3'd5
    } mode_t;

    // Active-low segments, bit 0 is A and bit 6 is G
    function automatic logic [SEG_W-1:0] hex_to_seg(input logic [3:0] nib);
        logic [SEG_W-1:0] pattern;
        case (nib)
            4'h0: pattern = 7'b100_0000;
            4'h1: pattern = 7'b111_1001;
            4'h2: pattern = 7'b010_0100;
            4'h3: pattern = 7'b011_0000;
            4'h4: pattern = 7'b001_1001;
            4'h5: pattern = 7'b001_0010;
            4'h6: pattern = 7'b000_0010;
            4'h7: pattern = 7'b111_1000;
            4'h8: pattern = 7'b000_0000;
            4'h9: pattern = 7'b001_0000;
            4'hA: pattern = 7'b000_1000;
            4'hB: pattern = 7'b000_0011;
            4'hC: pattern = 7'b100_0110;
            4'hD: pattern = 7'b010_0001;
            4'hE: pattern = 7'b000_0110;
            default: pattern = 7'b000_1110;  // F
        endcase
        return pattern;
    endfunction

endpackage

`default_nettype wire

// ==== panel_press_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// One-cycle press pulses, conditioner to sequencer
interface panel_press_if;
    logic up;      // Next mode
    logic down;    // Previous mode
    logic left;    // Read address down
    logic right;   // Read address up
    logic center;  // Write / start / reread

    modport src (
        output up, down, left, right, center
    );

    modport dst (
        input up, down, left, right, center
    );
endinterface

`default_nettype wire

// ==== button_conditioner.sv ====
`timescale 1ns/1ps
`default_nettype none

module button_conditioner #(
    parameter int DEBOUNCE_CYCLES = 1048576
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [panel_pkg::BTN_W-1:0] btn,    // Raw push buttons
    panel_press_if.src                  press
);
    import panel_pkg::*;

    localparam int CNT_W = (DEBOUNCE_CYCLES > 1) ? $clog2(DEBOUNCE_CYCLES) : 1;

    logic [CNT_W-1:0] period_cnt;   // Free running sample timer
    logic             sample_tick;
    logic [BTN_W-1:0] deb;          // Debounced level
    logic [BTN_W-1:0] deb_prev;     // Debounced level, one cycle late
    logic [BTN_W-1:0] pulse;        // Registered rising edges

    assign sample_tick = (period_cnt == CNT_W'(DEBOUNCE_CYCLES - 1));

    // ==================================================================
    // Sample timer and debounced level
    // ==================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            period_cnt <= '0;
            deb        <= '0;
        end else begin
            if (sample_tick) begin
                period_cnt <= '0;
                deb        <= btn;  // Bounce shorter than a period is lost here
            end else begin
                period_cnt <= period_cnt + 1'b1;
            end
        end
    end

    // Edge detect, pulse lands one cycle after deb rises
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            deb_prev <= '0;
            pulse    <= '0;
        end else begin
            deb_prev <= deb;
            pulse    <= deb & ~deb_prev;
        end
    end

    assign press.up     = pulse[BTN_UP];
    assign press.down   = pulse[BTN_DOWN];
    assign press.left   = pulse[BTN_LEFT];
    assign press.right  = pulse[BTN_RIGHT];
    assign press.center = pulse[BTN_CENTER];

    // A pulse only follows a held debounced level
    a_pulse_needs_level: assert property (@(posedge clk) disable iff (!rst_n)
        (pulse != '0) |-> ((pulse & ~deb) == '0));

endmodule

`default_nettype wire

// ==== panel_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module panel_sequencer (
    input  logic                               clk,
    input  logic                               rst_n,
    panel_press_if.dst                         press,
    input  logic [panel_pkg::SW_W-1:0]         sw,
    input  logic                               sys_busy,
    input  logic                               vpu_busy,
    input  logic                               ub_busy,
    input  logic [panel_pkg::UB_DATA_W-1:0]    ub_rd_data,
    output logic                               instr_wr_en,
    output logic [panel_pkg::INSTR_ADDR_W-1:0] instr_wr_addr,
    output logic [panel_pkg::INSTR_W-1:0]      instr_wr_data,
    output logic                               ub_wr_en,
    output logic [panel_pkg::UB_WR_ADDR_W-1:0] ub_wr_addr,
    output logic [panel_pkg::UB_DATA_W-1:0]    ub_wr_data,
    output logic                               ub_rd_en,
    output logic [panel_pkg::UB_RD_ADDR_W-1:0] ub_rd_addr,
    output logic                               wt_wr_en,
    output logic [panel_pkg::WT_ADDR_W-1:0]    wt_wr_addr,
    output logic [panel_pkg::WT_DATA_W-1:0]    wt_wr_data,
    output logic                               start_execution,
    output logic [panel_pkg::DISP_W-1:0]       display_value
);
    import panel_pkg::*;

    localparam int LOW_W = DISP_W - 4;  // Digits 2..0

    mode_t                   mode;
    logic [INSTR_ADDR_W-1:0] pc;        // Next instruction slot
    logic [UB_RD_ADDR_W-2:0] rd_addr;   // Bank bit added at the port
    logic                    do_instr;
    logic                    do_data;
    logic                    do_weight;
    logic                    do_start;
    logic                    do_read;
    logic [LOW_W-1:0]        disp_low;
    logic [4:0]              strobes;

    // ==================================================================
    // Centre / arrow decode per mode
    // ==================================================================
    assign do_instr  = press.center && (mode == INSTR);
    assign do_data   = press.center && (mode == DATA);
    assign do_weight = press.center && (mode == WEIGHT);
    assign do_start  = press.center && (mode == EXECUTE);
    assign do_read   = (mode == RESULTS) && (press.left || press.right || press.center);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode            <= IDLE;
            pc              <= '0;
            rd_addr         <= '0;
            instr_wr_en     <= 1'b0;
            ub_wr_en        <= 1'b0;
            wt_wr_en        <= 1'b0;
            ub_rd_en        <= 1'b0;
            start_execution <= 1'b0;
        end else begin
            if (press.up) begin  // Up wins over down
                mode <= (mode == RESULTS) ? IDLE : mode_t'(mode + 3'd1);
            end else if (press.down) begin
                mode <= (mode == IDLE) ? RESULTS : mode_t'(mode - 3'd1);
            end

            if (do_instr) begin
                pc <= pc + 1'b1;  // Wraps after 32 slots
            end

            if (mode == RESULTS) begin
                if (press.left) begin
                    rd_addr <= rd_addr - 1'b1;
                end else if (press.right) begin
                    rd_addr <= rd_addr + 1'b1;
                end
            end

            // Single-cycle strobes
            instr_wr_en     <= do_instr;
            ub_wr_en        <= do_data;
            wt_wr_en        <= do_weight;
            ub_rd_en        <= do_read;
            start_execution <= do_start;
        end
    end

    // Write payloads, captured alongside their strobe
    always_ff @(posedge clk) begin
        if (do_instr) begin
            instr_wr_addr <= pc;
            instr_wr_data <= INSTR_W'({sw, 2'b00});
        end
        if (do_data) begin
            ub_wr_addr <= sw[SW_W-1 -: UB_WR_ADDR_W];  // sw[15:8]
            ub_wr_data <= UB_DATA_W'(sw);
        end
        if (do_weight) begin
            wt_wr_addr <= sw[SW_W-1 -: WT_ADDR_W];     // sw[15:6]
            wt_wr_data <= WT_DATA_W'(sw);
        end
    end

    assign ub_rd_addr = {1'b0, rd_addr};  // Already holds the new address

    // ==================================================================
    // Display value, digit 3 is always the mode
    // ==================================================================
    always_comb begin
        case (mode)
            IDLE:    disp_low = LOW_W'(pc);
            INSTR:   disp_low = LOW_W'(sw[15:12]);          // Opcode nibble
            DATA:    disp_low = sw[11:0];
            WEIGHT:  disp_low = LOW_W'(sw[7:0]);
            EXECUTE: disp_low = {8'h00, sys_busy, vpu_busy, ub_busy, 1'b0};
            RESULTS: disp_low = LOW_W'(ub_rd_data[3:0]);
            default: disp_low = '0;
        endcase
    end

    assign display_value = {1'b0, mode, disp_low};

    assign strobes = {instr_wr_en, ub_wr_en, wt_wr_en, ub_rd_en, start_execution};

    a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(strobes));

    // Press pulses never arrive back to back
    a_strobe_single: assert property (@(posedge clk) disable iff (!rst_n)
        (strobes != '0) |=> (strobes == '0));

endmodule

`default_nettype wire

// ==== seven_seg_scanner.sv ====
`timescale 1ns/1ps
`default_nettype none

module seven_seg_scanner #(
    parameter int REFRESH_CYCLES = 100000
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [panel_pkg::DISP_W-1:0] display_value,
    output logic [panel_pkg::SEG_W-1:0]  seg,            // Active low
    output logic [panel_pkg::DIGITS-1:0] an              // Active low
);
    import panel_pkg::*;

    localparam int CNT_W = (REFRESH_CYCLES > 1) ? $clog2(REFRESH_CYCLES) : 1;
    localparam int SEL_W = $clog2(DIGITS);

    logic [CNT_W-1:0] refresh_cnt;
    logic [SEL_W-1:0] digit_sel;   // 0 is rightmost digit
    logic [3:0]       nibble;

    // ==================================================================
    // Refresh timer and digit rotation
    // ==================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            refresh_cnt <= '0;
            digit_sel   <= '0;
        end else begin
            if (refresh_cnt == CNT_W'(REFRESH_CYCLES - 1)) begin
                refresh_cnt <= '0;
                // 0, 1, 2, 3, back to 0
                if (digit_sel == SEL_W'(DIGITS - 1)) begin
                    digit_sel <= '0;
                end else begin
                    digit_sel <= digit_sel + 1'b1;
                end
            end else begin
                refresh_cnt <= refresh_cnt + 1'b1;
            end
        end
    end

    // Selected nibble straight to segments, same cycle
    assign nibble = display_value[{digit_sel, 2'b00} +: 4];
    assign seg    = hex_to_seg(nibble);
    assign an     = ~(DIGITS'(1) << digit_sel);  // One anode low

    a_an_onehot_low: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot(~an));

endmodule

`default_nettype wire

// ==== tpu_front_panel.sv ====
`timescale 1ns/1ps
`default_nettype none

module tpu_front_panel #(
    parameter int DEBOUNCE_CYCLES = 1048576,  // ~10 ms at 100 MHz
    parameter int REFRESH_CYCLES  = 100000    // 1 ms per digit
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [panel_pkg::SW_W-1:0]         sw,
    input  logic [panel_pkg::BTN_W-1:0]        btn,        // U, D, L, R, C
    input  logic                               sys_busy,
    input  logic                               vpu_busy,
    input  logic                               ub_busy,
    input  logic [panel_pkg::UB_DATA_W-1:0]    ub_rd_data,
    output logic [panel_pkg::SEG_W-1:0]        seg,
    output logic [panel_pkg::DIGITS-1:0]       an,
    output logic                               instr_wr_en,
    output logic [panel_pkg::INSTR_ADDR_W-1:0] instr_wr_addr,
    output logic [panel_pkg::INSTR_W-1:0]      instr_wr_data,
    output logic                               ub_wr_en,
    output logic [panel_pkg::UB_WR_ADDR_W-1:0] ub_wr_addr,
    output logic [panel_pkg::UB_DATA_W-1:0]    ub_wr_data,
    output logic                               ub_rd_en,
    output logic [panel_pkg::UB_RD_ADDR_W-1:0] ub_rd_addr,
    output logic                               wt_wr_en,
    output logic [panel_pkg::WT_ADDR_W-1:0]    wt_wr_addr,
    output logic [panel_pkg::WT_DATA_W-1:0]    wt_wr_data,
    output logic                               start_execution
);
    import panel_pkg::*;

    logic [DISP_W-1:0] display_value;  // Sequencer to scanner

    panel_press_if press_bus ();

    button_conditioner #(
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) u_conditioner (
        .clk   (clk),
        .rst_n (rst_n),
        .btn   (btn),
        .press (press_bus.src)
    );

    panel_sequencer u_sequencer (
        .clk             (clk),
        .rst_n           (rst_n),
        .press           (press_bus.dst),
        .sw              (sw),
        .sys_busy        (sys_busy),
        .vpu_busy        (vpu_busy),
        .ub_busy         (ub_busy),
        .ub_rd_data      (ub_rd_data),
        .instr_wr_en     (instr_wr_en),
        .instr_wr_addr   (instr_wr_addr),
        .instr_wr_data   (instr_wr_data),
        .ub_wr_en        (ub_wr_en),
        .ub_wr_addr      (ub_wr_addr),
        .ub_wr_data      (ub_wr_data),
        .ub_rd_en        (ub_rd_en),
        .ub_rd_addr      (ub_rd_addr),
        .wt_wr_en        (wt_wr_en),
        .wt_wr_addr      (wt_wr_addr),
        .wt_wr_data      (wt_wr_data),
        .start_execution (start_execution),
        .display_value   (display_value)
    );

    seven_seg_scanner #(
        .REFRESH_CYCLES (REFRESH_CYCLES)
    ) u_scanner (
        .clk           (clk),
        .rst_n         (rst_n),
        .display_value (display_value),
        .seg           (seg),
        .an            (an)
    );

endmodule

`default_nettype wire

// ==== tb_front_panel.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_front_panel;
    import panel_pkg::*;

    localparam int DEB        = 8;                              // Debounce period in clocks
    localparam int REF        = 4;                              // Clocks per digit
    localparam int MAX_ROWS   = 32;
    localparam int ROW_CYCLES = 4 * DEB + 2 * DIGITS * REF;     // Press, release, display
    localparam int LIMIT      = MAX_ROWS * ROW_CYCLES + 200;

    // Strobe kinds as bit index into strobes
    localparam int K_NONE  = 0;
    localparam int K_INSTR = 1;
    localparam int K_UBWR  = 2;
    localparam int K_WT    = 3;
    localparam int K_START = 4;
    localparam int K_UBRD  = 5;

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic [SW_W-1:0]         sw;
    logic [BTN_W-1:0]        btn;
    logic                    sys_busy;
    logic                    vpu_busy;
    logic                    ub_busy;
    logic [UB_DATA_W-1:0]    ub_rd_data;
    logic [SEG_W-1:0]        seg;
    logic [DIGITS-1:0]       an;
    logic                    instr_wr_en;
    logic [INSTR_ADDR_W-1:0] instr_wr_addr;
    logic [INSTR_W-1:0]      instr_wr_data;
    logic                    ub_wr_en;
    logic [UB_WR_ADDR_W-1:0] ub_wr_addr;
    logic [UB_DATA_W-1:0]    ub_wr_data;
    logic                    ub_rd_en;
    logic [UB_RD_ADDR_W-1:0] ub_rd_addr;
    logic                    wt_wr_en;
    logic [WT_ADDR_W-1:0]    wt_wr_addr;
    logic [WT_DATA_W-1:0]    wt_wr_data;
    logic                    start_execution;
    logic [5:1]              strobes;

    // ==================================================================
    // Stimulus table with one row per button press
    // ==================================================================
    int           t_btn  [MAX_ROWS];
    logic [15:0]  t_sw   [MAX_ROWS];
    int           t_kind [MAX_ROWS];
    logic [9:0]   t_addr [MAX_ROWS];
    logic [31:0]  t_data [MAX_ROWS];
    logic [3:0]   t_mode [MAX_ROWS];   // Expected digit 3
    logic [11:0]  t_low  [MAX_ROWS];   // Expected digits 2..0
    logic [2:0]   t_busy [MAX_ROWS];   // sys, vpu, ub
    logic [255:0] t_rd   [MAX_ROWS];
    int           n_rows      = 0;
    int           m_mode      = 0;     // Reference panel state
    int           m_pc        = 0;
    int           m_rd        = 0;
    integer       seed        = 5437;
    int           cycle_cnt   = 0;

    assign strobes = {ub_rd_en, start_execution, wt_wr_en, ub_wr_en, instr_wr_en};

    always #10 clk = ~clk;  // 20 ns period

    tpu_front_panel #(
        .DEBOUNCE_CYCLES (DEB),
        .REFRESH_CYCLES  (REF)
    ) dut (
        .clk (clk), .rst_n (rst_n), .sw (sw), .btn (btn),
        .sys_busy (sys_busy), .vpu_busy (vpu_busy), .ub_busy (ub_busy),
        .ub_rd_data (ub_rd_data), .seg (seg), .an (an),
        .instr_wr_en (instr_wr_en), .instr_wr_addr (instr_wr_addr),
        .instr_wr_data (instr_wr_data), .ub_wr_en (ub_wr_en), .ub_wr_addr (ub_wr_addr),
        .ub_wr_data (ub_wr_data), .ub_rd_en (ub_rd_en), .ub_rd_addr (ub_rd_addr),
        .wt_wr_en (wt_wr_en), .wt_wr_addr (wt_wr_addr), .wt_wr_data (wt_wr_data),
        .start_execution (start_execution)
    );

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [255:0] got,
                               input logic [255:0] exp);
        if (got !== exp)
            stop_on_error($sformatf("Mismatch at %0t ns: %s got %0h expected %0h",
                                    $time, name, got, exp));
    endtask

    // Adds one press and its expected outcome
    task automatic add_step(input int b);
        int           rnd;
        int           r;
        logic [15:0]  s;
        logic [255:0] rd;
        r   = n_rows;
        rnd = $random(seed);
        s   = rnd[15:0];
        rd  = {$random(seed), $random(seed), $random(seed), $random(seed),
               $random(seed), $random(seed), $random(seed), $random(seed)};
        t_btn[r]  = b;
        t_sw[r]   = s;
        t_rd[r]   = rd;
        t_busy[r] = 3'b100 >> (r % 3);  // Walking busy bit
        t_kind[r] = K_NONE;
        t_addr[r] = '0;
        t_data[r] = '0;
        if (b == BTN_UP) begin
            m_mode = (m_mode == 5) ? 0 : m_mode + 1;
        end else if (b == BTN_DOWN) begin
            m_mode = (m_mode == 0) ? 5 : m_mode - 1;
        end else if (b == BTN_LEFT || b == BTN_RIGHT) begin
            if (m_mode == 5) begin  // Arrows only move in RESULTS
                m_rd = (b == BTN_LEFT) ? (m_rd + 255) % 256 : (m_rd + 1) % 256;
                t_kind[r] = K_UBRD;
                t_addr[r] = m_rd;
            end
        end else begin
            case (m_mode)
                1: begin
                    t_kind[r] = K_INSTR;
                    t_addr[r] = m_pc;
                    t_data[r] = {14'b0, s, 2'b00};
                    m_pc = (m_pc + 1) % 32;
                end
                2: begin
                    t_kind[r] = K_UBWR;
                    t_addr[r] = s[15:8];
                    t_data[r] = s;
                end
                3: begin
                    t_kind[r] = K_WT;
                    t_addr[r] = s[15:6];
                    t_data[r] = s;
                end
                4: t_kind[r] = K_START;
                5: begin  // Reread
                    t_kind[r] = K_UBRD;
                    t_addr[r] = m_rd;
                end
                default: t_kind[r] = K_NONE;
            endcase
        end
        t_mode[r] = m_mode;
        case (m_mode)
            0: t_low[r] = m_pc;
            1: t_low[r] = s[15:12];
            2: t_low[r] = s[11:0];
            3: t_low[r] = s[7:0];
            4: t_low[r] = {8'h00, t_busy[r], 1'b0};
            default: t_low[r] = rd[3:0];
        endcase
        n_rows++;
    endtask

    task automatic build_table();
        repeat (6) add_step(BTN_UP);      // Modes 1..5 then wrap to 0
        add_step(BTN_DOWN);               // 0 back to 5
        add_step(BTN_UP);
        add_step(BTN_UP);                 // INSTR
        repeat (3) add_step(BTN_CENTER);  // pc 0, 1, 2
        add_step(BTN_DOWN);               // IDLE shows pc
        repeat (2) add_step(BTN_UP);      // DATA
        repeat (2) add_step(BTN_CENTER);
        add_step(BTN_UP);                 // WEIGHT
        repeat (2) add_step(BTN_CENTER);
        add_step(BTN_UP);                 // EXECUTE
        add_step(BTN_CENTER);
        add_step(BTN_LEFT);               // No read here
        add_step(BTN_UP);                 // RESULTS
        add_step(BTN_RIGHT);
        add_step(BTN_RIGHT);
        add_step(BTN_LEFT);
        add_step(BTN_CENTER);
        add_step(BTN_DOWN);
        add_step(BTN_UP);
    endtask

    task automatic check_payload(input int r);
        case (t_kind[r])
            K_INSTR: begin
                check_value("instr_wr_addr", instr_wr_addr, t_addr[r]);
                check_value("instr_wr_data", instr_wr_data, t_data[r]);
            end
            K_UBWR: begin
                check_value("ub_wr_addr", ub_wr_addr, t_addr[r]);
                check_value("ub_wr_data", ub_wr_data, t_data[r]);
            end
            K_WT: begin
                check_value("wt_wr_addr", wt_wr_addr, t_addr[r]);
                check_value("wt_wr_data", wt_wr_data, t_data[r]);
            end
            K_UBRD: check_value("ub_rd_addr", ub_rd_addr, t_addr[r]);  // Bank bit 0
            default: ;
        endcase
    endtask

    // Waits for the digit's anode, then checks its segments
    task automatic check_digit(input int d, input logic [3:0] nib);
        logic [3:0] want_an;
        want_an = ~(4'b0001 << d);
        @(negedge clk);
        while (an !== want_an) @(negedge clk);
        check_value($sformatf("seg (digit %0d)", d), seg, hex_to_seg(nib));
    endtask

    task automatic check_display(input logic [3:0] mode_nib, input logic [11:0] low);
        check_digit(0, low[3:0]);
        check_digit(1, low[7:4]);
        check_digit(2, low[11:8]);
        check_digit(3, mode_nib);
    endtask

    // ==================================================================
    // One row does press and release, watches strobes, then the display
    // ==================================================================
    task automatic apply_row(input int r);
        int hits;
        int c;
        int k;
        hits = 0;
        for (c = 0; c < 4 * DEB; c++) begin
            @(posedge clk);
            if (c == 0) begin
                sw         <= t_sw[r];
                btn        <= BTN_W'(1) << t_btn[r];
                sys_busy   <= t_busy[r][2];
                vpu_busy   <= t_busy[r][1];
                ub_busy    <= t_busy[r][0];
                ub_rd_data <= t_rd[r];
            end else if (c == 2 * DEB) begin
                btn <= '0;  // Release
            end
            @(negedge clk);
            for (k = 1; k <= 5; k++) begin
                if (strobes[k] === 1'b1) begin
                    if (k != t_kind[r])
                        stop_on_error($sformatf("Row %0d: unexpected strobe kind %0d at %0t ns",
                                                r, k, $time));
                    hits++;
                    check_payload(r);
                end
            end
        end
        if (hits != ((t_kind[r] == K_NONE) ? 0 : 1))
            stop_on_error($sformatf("Row %0d: strobe kind %0d seen %0d times, wanted once",
                                    r, t_kind[r], hits));
        check_display(t_mode[r], t_low[r]);
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= LIMIT)
            stop_on_error($sformatf("Timeout: run still going after %0d cycles", LIMIT));
    end

    initial begin
        rst_n      <= 1'b0;
        sw         <= '0;
        btn        <= '0;
        sys_busy   <= 1'b0;
        vpu_busy   <= 1'b0;
        ub_busy    <= 1'b0;
        ub_rd_data <= '0;
        build_table();
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("strobes", strobes, '0);
        check_value("an", an, 4'b1110);
        check_display(4'h0, 12'h000);  // IDLE with pc 000
        for (int r = 0; r < n_rows; r++) begin
            apply_row(r);
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
panel_pkg.sv
panel_press_if.sv
button_conditioner.sv
panel_sequencer.sv
seven_seg_scanner.sv
tpu_front_panel.sv
tb_front_panel.sv

// ==== Bender.yml ====
package:
  name: tpu_front_panel

sources:
  - panel_pkg.sv
  - panel_press_if.sv
  - button_conditioner.sv
  - panel_sequencer.sv
  - seven_seg_scanner.sv
  - tpu_front_panel.sv
  - target: simulation
    files:
      - tb_front_panel.sv
